// File: hw/core_sb_pkg.sv
package core_sb_pkg;

   localparam int num_lanes = 4;
   localparam int num_gpr   = 32;
   localparam int num_pred  = 3;

   localparam int reg_num_w  = 5;
   localparam int pred_num_w = 2;

   typedef logic [reg_num_w-1:0]  reg_num_t;
   typedef logic [pred_num_w-1:0] pred_num_t;
   typedef logic [num_gpr-1:0]    gpr_mask_t;
   typedef logic [num_pred-1:0]   pred_mask_t;

   // One decoded lane.
   typedef struct packed {
      reg_num_t  rd;
      logic      rd_we;
      logic      pred_we;    // Target predicate is rd[1:0].
      reg_num_t  rs1;
      reg_num_t  rs2;
      pred_num_t pred_src;
      logic      pred_use;
   } lane_op_t;

   typedef lane_op_t [num_lanes-1:0] bundle_t;

   typedef struct packed {
      reg_num_t rd;
      logic     rd_we;
      logic     pred_we;
   } wb_lane_t;

   typedef wb_lane_t [num_lanes-1:0] wb_bundle_t;

   typedef struct packed {
      reg_num_t rd;
      logic     rd_we;
      logic     pred_we;
   } dst_lane_t;

   typedef dst_lane_t [num_lanes-1:0] dst_bundle_t;

   function automatic gpr_mask_t gpr_onehot(reg_num_t r);
      return gpr_mask_t'(1) << r;
   endfunction

   // Predicate 3 falls outside the mask.
   function automatic pred_mask_t pred_onehot(pred_num_t p);
      return pred_mask_t'(1) << p;
   endfunction

   function automatic pred_num_t dst_pred(reg_num_t rd);
      return rd[pred_num_w-1:0];
   endfunction

   function automatic logic pred_is_busy(pred_mask_t mask, pred_num_t p);
      return |(mask & pred_onehot(p));
   endfunction

endpackage

// File: hw/core_scoreboard.sv
`timescale 1ns/1ps

module core_scoreboard (
   input  logic                     clkrst_core_clk,
   input  logic                     clkrst_core_rst_n,
   input  core_sb_pkg::dst_bundle_t dst,
   input  logic                     progress,
   input  logic                     exception,
   input  core_sb_pkg::wb_bundle_t  wb,
   output core_sb_pkg::gpr_mask_t   reg_busy,
   output core_sb_pkg::pred_mask_t  pred_busy
);

   import core_sb_pkg::*;

   gpr_mask_t  set_reg_d;
   pred_mask_t set_pred_d;
   gpr_mask_t  clr_reg_d;
   pred_mask_t clr_pred_d;

   gpr_mask_t  set_reg_q;
   pred_mask_t set_pred_q;
   gpr_mask_t  clr_reg_q;
   pred_mask_t clr_pred_q;

   gpr_mask_t  prev_reg;
   pred_mask_t prev_pred;

   gpr_mask_t  new_reg;
   pred_mask_t new_pred;

   // One-hot sets from the issuing bundle.
   always_comb begin
      set_reg_d  = '0;
      set_pred_d = '0;
      for (int i = 0; i < num_lanes; i++) begin
         if (progress && dst[i].rd_we)
            set_reg_d = set_reg_d | gpr_onehot(dst[i].rd);
         if (progress && dst[i].pred_we)
            set_pred_d = set_pred_d | pred_onehot(dst_pred(dst[i].rd));
      end
   end

   // One-hot clears from writeback.
   always_comb begin
      clr_reg_d  = '0;
      clr_pred_d = '0;
      for (int i = 0; i < num_lanes; i++) begin
         if (wb[i].rd_we)
            clr_reg_d = clr_reg_d | gpr_onehot(wb[i].rd);
         if (wb[i].pred_we)
            clr_pred_d = clr_pred_d | pred_onehot(dst_pred(wb[i].rd));
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         set_reg_q  <= '0;
         set_pred_q <= '0;
         clr_reg_q  <= '0;
         clr_pred_q <= '0;
         prev_reg   <= '0;
         prev_pred  <= '0;
      end else begin
         set_reg_q  <= set_reg_d;
         set_pred_q <= set_pred_d;
         clr_reg_q  <= clr_reg_d;
         clr_pred_q <= clr_pred_d;
         prev_reg   <= reg_busy;
         prev_pred  <= pred_busy;
      end
   end

   // A bundle squashed this cycle never marks its targets.
   assign new_reg  = set_reg_q & ~{num_gpr{exception}};
   assign new_pred = set_pred_q & ~{num_pred{exception}};

   assign reg_busy  = (prev_reg | new_reg) & ~clr_reg_q;
   assign pred_busy = (prev_pred | new_pred) & ~clr_pred_q;

   // Writeback must match an earlier unsquashed issue.
   a_clear_only_busy : assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      ((clr_reg_q & ~(prev_reg | new_reg)) == '0) &&
      ((clr_pred_q & ~(prev_pred | new_pred)) == '0)
   ) else $error("Writeback clears a register that is not pending");

endmodule

// File: hw/core_issue_ctrl.sv
`timescale 1ns/1ps

module core_issue_ctrl (
   input  logic                     clkrst_core_clk,
   input  logic                     clkrst_core_rst_n,
   input  core_sb_pkg::bundle_t     bundle,
   input  logic                     bundle_valid,
   input  logic                     pipe_flush,
   input  core_sb_pkg::gpr_mask_t   reg_busy,
   input  core_sb_pkg::pred_mask_t  pred_busy,
   output logic                     bundle_ready,
   output logic                     progress,
   output core_sb_pkg::dst_bundle_t dst
);

   import core_sb_pkg::*;

   localparam int stall_cnt_w = 8;

   typedef logic [stall_cnt_w-1:0] stall_cnt_t;

   logic [num_lanes-1:0] src_busy;
   logic [num_lanes-1:0] dst_busy;
   logic                 hazard;

   stall_cnt_t stall_cnt;

   // Per-lane RAW and WAW checks.
   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         src_busy[i] = reg_busy[bundle[i].rs1] | reg_busy[bundle[i].rs2] |
                       (bundle[i].pred_use & pred_is_busy(pred_busy, bundle[i].pred_src));
         dst_busy[i] = (bundle[i].rd_we & reg_busy[bundle[i].rd]) |
                       (bundle[i].pred_we & pred_is_busy(pred_busy, dst_pred(bundle[i].rd)));
      end
   end

   assign hazard       = |(src_busy | dst_busy);
   assign bundle_ready = bundle_valid & ~pipe_flush & ~hazard;
   assign progress     = bundle_valid & bundle_ready;

   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         dst[i].rd      = bundle[i].rd;
         dst[i].rd_we   = bundle[i].rd_we & progress;   // Enables only on acceptance.
         dst[i].pred_we = bundle[i].pred_we & progress;
      end
   end

   // Saturating count of cycles a bundle waits.
   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         stall_cnt <= '0;
      end else if (bundle_valid && !bundle_ready) begin
         if (stall_cnt != '1)
            stall_cnt <= stall_cnt + 1'b1;
      end else begin
         stall_cnt <= '0;
      end
   end

   // A stalled bundle stays put until it is taken.
   a_hold_while_stalled : assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      (stall_cnt != '0) |-> bundle_valid && $stable(bundle)
   ) else $error("Bundle changed while stalled for %0d cycles", stall_cnt);

endmodule

// File: hw/core_exec_pipe.sv
`timescale 1ns/1ps

module core_exec_pipe #(
   parameter int exec_latency = 3
) (
   input  logic                     clkrst_core_clk,
   input  logic                     clkrst_core_rst_n,
   input  core_sb_pkg::dst_bundle_t dst,
   input  logic                     progress,
   input  logic                     exception,
   output core_sb_pkg::wb_bundle_t  wb
);

   import core_sb_pkg::*;

   // Stage 0 is the issue register, then exec_latency shift stages.
   dst_bundle_t stage_q [exec_latency+1];

   if (exec_latency < 2) begin : g_bad_latency
      $error("exec_latency must be 2 or more, got %0d", exec_latency);
   end

   function automatic dst_bundle_t kill_lanes(dst_bundle_t b);
      dst_bundle_t k;
      k = b;
      for (int i = 0; i < num_lanes; i++) begin
         k[i].rd_we   = 1'b0;
         k[i].pred_we = 1'b0;
      end
      return k;
   endfunction

   function automatic logic dup_dst(wb_bundle_t w);
      logic dup;
      dup = 1'b0;
      for (int i = 0; i < num_lanes; i++) begin
         for (int j = i + 1; j < num_lanes; j++) begin
            if (w[i].rd_we && w[j].rd_we && w[i].rd == w[j].rd)
               dup = 1'b1;
            if (w[i].pred_we && w[j].pred_we && dst_pred(w[i].rd) == dst_pred(w[j].rd))
               dup = 1'b1;
         end
      end
      return dup;
   endfunction

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int s = 0; s <= exec_latency; s++) begin
            stage_q[s] <= '0;
         end
      end else begin
         stage_q[0] <= progress ? dst : '0;                     // Bubble when idle.
         stage_q[1] <= exception ? kill_lanes(stage_q[0]) : stage_q[0];
         for (int s = 2; s <= exec_latency; s++) begin
            stage_q[s] <= stage_q[s-1];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         wb[i].rd      = stage_q[exec_latency][i].rd;
         wb[i].rd_we   = stage_q[exec_latency][i].rd_we;
         wb[i].pred_we = stage_q[exec_latency][i].pred_we;
      end
   end

   // Decode never pairs two writers of one register.
   a_unique_wb_dst : assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      !dup_dst(wb)
   ) else $error("Two writeback lanes target the same register");

endmodule

// File: hw/core_sb_top.sv
`timescale 1ns/1ps

module core_sb_top #(
   parameter int exec_latency = 3
) (
   input  logic                    clkrst_core_clk,
   input  logic                    clkrst_core_rst_n,
   input  core_sb_pkg::bundle_t    bundle,
   input  logic                    bundle_valid,
   output logic                    bundle_ready,
   input  logic                    pipe_flush,
   input  logic                    exception,
   output core_sb_pkg::wb_bundle_t wb,
   output core_sb_pkg::gpr_mask_t  reg_busy,
   output core_sb_pkg::pred_mask_t pred_busy
);

   import core_sb_pkg::*;

   dst_bundle_t dst;
   logic        progress;

   core_issue_ctrl i_issue_ctrl (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle            (bundle),
      .bundle_valid      (bundle_valid),
      .pipe_flush        (pipe_flush),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy),
      .bundle_ready      (bundle_ready),
      .progress          (progress),
      .dst               (dst)
   );

   core_scoreboard i_scoreboard (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .dst               (dst),
      .progress          (progress),
      .exception         (exception),
      .wb                (wb),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy)
   );

   core_exec_pipe #(
      .exec_latency (exec_latency)
   ) i_exec_pipe (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .dst               (dst),
      .progress          (progress),
      .exception         (exception),
      .wb                (wb)
   );

endmodule

// File: tests/tb_core_sb_tasks.svh
function automatic lane_op_t make_lane(reg_num_t rd, logic rd_we, logic pred_we,
                                       reg_num_t rs1, reg_num_t rs2,
                                       pred_num_t pred_src, logic pred_use);
   lane_op_t l;
   l.rd       = rd;
   l.rd_we    = rd_we;
   l.pred_we  = pred_we;
   l.rs1      = rs1;
   l.rs2      = rs2;
   l.pred_src = pred_src;
   l.pred_use = pred_use;
   return l;
endfunction

// Empty lane reads r0, which no test writes.
function automatic bundle_t empty_bundle();
   bundle_t b;
   for (int i = 0; i < num_lanes; i++) begin
      b[i] = make_lane(5'd0, 1'b0, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   end
   return b;
endfunction

function automatic gpr_mask_t writes_of(bundle_t b);
   gpr_mask_t m;
   m = '0;
   for (int i = 0; i < num_lanes; i++) begin
      if (b[i].rd_we)
         m[b[i].rd] = 1'b1;
   end
   return m;
endfunction

function automatic pred_mask_t pred_writes_of(bundle_t b);
   pred_mask_t m;
   m = '0;
   for (int i = 0; i < num_lanes; i++) begin
      if (b[i].pred_we && b[i].rd[1:0] < 2'd3)
         m[b[i].rd[1:0]] = 1'b1;
   end
   return m;
endfunction

function automatic wb_bundle_t wb_of(bundle_t b);
   wb_bundle_t w;
   for (int i = 0; i < num_lanes; i++) begin
      w[i].rd      = b[i].rd;
      w[i].rd_we   = b[i].rd_we;
      w[i].pred_we = b[i].pred_we;
   end
   return w;
endfunction

// A lane with both enables low carries no register number.
function automatic wb_bundle_t live_lanes(wb_bundle_t w);
   wb_bundle_t l;
   l = w;
   for (int i = 0; i < num_lanes; i++) begin
      if (!w[i].rd_we && !w[i].pred_we)
         l[i].rd = '0;
   end
   return l;
endfunction

task automatic check_bit(string name, logic exp, logic act);
   if (exp !== act) begin
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
   end
endtask

task automatic check_gpr(string name, gpr_mask_t exp, gpr_mask_t act);
   if (exp !== act) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
   end
endtask

task automatic check_pred(string name, pred_mask_t exp, pred_mask_t act);
   if (exp !== act) begin
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
   end
endtask

task automatic check_wb(string name, wb_bundle_t exp, wb_bundle_t act);
   if (live_lanes(exp) !== live_lanes(act)) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
   end
endtask

task automatic finish_test(string name, int errors_before);
   tests_run++;
   if (errors > errors_before) begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, errors - errors_before);
   end else begin
      $display("Test %s: ok", name);
   end
endtask

// Eight distinct nonzero register numbers.
task automatic fill_picks();
   int       n;
   reg_num_t c;
   logic     dup;
   n = 0;
   while (n < 8) begin
      c   = reg_num_t'($random(seed));
      dup = (c == 5'd0);
      for (int j = 0; j < n; j++) begin
         if (picks[j] == c)
            dup = 1'b1;
      end
      if (!dup) begin
         picks[n] = c;
         n++;
      end
   end
endtask

// Returns at the falling edge right after the accepting edge.
task automatic issue_one(bundle_t b, output int acc);
   int n;
   @(posedge clkrst_core_clk);
   bundle       <= b;
   bundle_valid <= 1'b1;
   pipe_flush   <= 1'b0;
   n = 0;
   @(negedge clkrst_core_clk);
   while (!bundle_ready && n < 4 * lat + 20) begin
      n++;
      @(negedge clkrst_core_clk);
   end
   if (!bundle_ready) begin
      stop_on_timeout("bundle_ready never rose for a waiting bundle");
   end else begin
      @(posedge clkrst_core_clk);
      acc = cyc;
      bundle_valid <= 1'b0;
      @(negedge clkrst_core_clk);
   end
endtask

task automatic issue_pair(bundle_t a, bundle_t b, logic squash);
   @(posedge clkrst_core_clk);
   bundle       <= a;
   bundle_valid <= 1'b1;
   pipe_flush   <= 1'b0;
   @(negedge clkrst_core_clk);
   if (!bundle_ready) begin
      stop_on_timeout("first bundle of a pair was not taken at once");
   end else begin
      @(posedge clkrst_core_clk);
      bundle <= b;
      @(negedge clkrst_core_clk);
      check_gpr("reg_busy", writes_of(a), reg_busy);
      if (!bundle_ready) begin
         stop_on_timeout("second bundle of a pair was not taken back to back");
      end else begin
         @(posedge clkrst_core_clk);
         bundle_valid <= 1'b0;
         if (squash)
            exception <= 1'b1;
         @(negedge clkrst_core_clk);
      end
   end
endtask

// Steps k = 1 .. lat+2 after the first acceptance.
task automatic check_pair_timeline(gpr_mask_t ma, gpr_mask_t mb,
                                   wb_bundle_t wa, wb_bundle_t wbb);
   gpr_mask_t  exp_busy;
   wb_bundle_t exp_wb;
   for (int k = 1; k <= lat + 2; k++) begin
      if (k > 1) begin
         @(posedge clkrst_core_clk);
         exception <= 1'b0;
         @(negedge clkrst_core_clk);
      end
      exp_busy = (k <= lat ? ma : '0) | (k <= lat + 1 ? mb : '0);
      exp_wb   = (k == lat) ? wa : ((k == lat + 1) ? wbb : '0);
      check_gpr("reg_busy", exp_busy, reg_busy);
      check_pred("pred_busy", '0, pred_busy);
      check_wb("wb", exp_wb, wb);
   end
endtask

task automatic check_single_timeline(bundle_t b);
   for (int k = 0; k <= lat + 1; k++) begin
      if (k > 0)
         @(negedge clkrst_core_clk);
      check_gpr("reg_busy", k <= lat ? writes_of(b) : '0, reg_busy);
      check_pred("pred_busy", k <= lat ? pred_writes_of(b) : '0, pred_busy);
      check_wb("wb", k == lat ? wb_of(b) : '0, wb);
   end
endtask

task automatic drain();
   int n;
   n = 0;
   while ((reg_busy != '0 || pred_busy != '0) && n < 4 * lat + 20) begin
      n++;
      @(negedge clkrst_core_clk);
   end
   if (reg_busy != '0 || pred_busy != '0) begin
      stop_on_timeout("busy masks never returned to zero");
   end else begin
      repeat (lat + 2) @(negedge clkrst_core_clk);
   end
endtask

task automatic test_back_to_back();
   bundle_t a;
   bundle_t b;
   int      e0;
   e0 = errors;
   fill_picks();
   a = empty_bundle();
   b = empty_bundle();
   for (int i = 0; i < num_lanes; i++) begin
      a[i] = make_lane(picks[i], 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
      b[i] = make_lane(picks[4+i], 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   end
   issue_pair(a, b, 1'b0);
   check_pair_timeline(writes_of(a), writes_of(b), wb_of(a), wb_of(b));
   drain();
   finish_test("back_to_back", e0);
endtask

// Second bundle may issue one edge after the first one's bits fall.
task automatic dependent_pair(string name, bundle_t a, bundle_t b);
   int e0;
   int acc_a;
   int acc_b;
   e0 = errors;
   issue_one(a, acc_a);
   check_gpr("reg_busy", writes_of(a), reg_busy);
   check_pred("pred_busy", pred_writes_of(a), pred_busy);
   issue_one(b, acc_b);
   if (acc_b != acc_a + lat + 2) begin
      $display("Error at %0t ns: accept edge expected %0d, got %0d",
               $time, acc_a + lat + 2, acc_b);
      errors++;
   end
   check_single_timeline(b);
   drain();
   finish_test(name, e0);
endtask

task automatic test_raw_hazard();
   bundle_t a;
   bundle_t b;
   a    = empty_bundle();
   b    = empty_bundle();
   a[0] = make_lane(5'd5, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   b[2] = make_lane(5'd6, 1'b1, 1'b0, 5'd5, 5'd0, 2'd0, 1'b0);
   dependent_pair("raw_hazard", a, b);
endtask

task automatic test_pred_hazard();
   bundle_t a;
   bundle_t b;
   a    = empty_bundle();
   b    = empty_bundle();
   a[1] = make_lane(5'd2, 1'b0, 1'b1, 5'd0, 5'd0, 2'd0, 1'b0);   // Writes p2.
   b[3] = make_lane(5'd7, 1'b1, 1'b0, 5'd0, 5'd0, 2'd2, 1'b1);
   dependent_pair("pred_hazard", a, b);
endtask

task automatic test_waw_hazard();
   bundle_t a;
   bundle_t b;
   a    = empty_bundle();
   b    = empty_bundle();
   a[0] = make_lane(5'd9, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   b[1] = make_lane(5'd9, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   dependent_pair("waw_hazard", a, b);
endtask

task automatic test_flush();
   bundle_t b;
   int      e0;
   int      acc;
   e0   = errors;
   b    = empty_bundle();
   b[0] = make_lane(5'd12, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   b[1] = make_lane(5'd1, 1'b0, 1'b1, 5'd0, 5'd0, 2'd0, 1'b0);
   @(posedge clkrst_core_clk);
   pipe_flush   <= 1'b1;
   bundle       <= b;
   bundle_valid <= 1'b1;
   repeat (lat + 2) begin
      @(negedge clkrst_core_clk);
      check_bit("bundle_ready", 1'b0, bundle_ready);
      check_gpr("reg_busy", '0, reg_busy);
      check_pred("pred_busy", '0, pred_busy);
      check_wb("wb", '0, wb);
   end
   issue_one(b, acc);
   check_single_timeline(b);
   drain();
   finish_test("flush", e0);
endtask

task automatic test_exception();
   bundle_t a;
   bundle_t b;
   int      e0;
   e0   = errors;
   a    = empty_bundle();
   b    = empty_bundle();
   a[0] = make_lane(5'd20, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   b[0] = make_lane(5'd21, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   b[2] = make_lane(5'd22, 1'b1, 1'b0, 5'd0, 5'd0, 2'd0, 1'b0);
   issue_pair(a, b, 1'b1);
   check_pair_timeline(writes_of(a), '0, wb_of(a), '0);
   @(posedge clkrst_core_clk);
   exception <= 1'b0;
   drain();
   finish_test("exception", e0);
endtask

// File: tests/tb_core_sb.sv
`timescale 1ns/1ps

module tb_core_sb;

   import core_sb_pkg::*;

   logic        clkrst_core_clk;
   logic        clkrst_core_rst_n;
   bundle_t     bundle;
   logic        bundle_valid;
   logic        bundle_ready;
   logic        pipe_flush;
   logic        exception;
   wb_bundle_t  wb;
   gpr_mask_t   reg_busy;
   pred_mask_t  pred_busy;

   int          cyc;          // Rising edges seen so far.
   int          lat;
   int          seed;
   int          errors;
   int          tests_run;
   int          tests_failed;
   reg_num_t    picks [8];

   core_sb_top i_dut (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle            (bundle),
      .bundle_valid      (bundle_valid),
      .bundle_ready      (bundle_ready),
      .pipe_flush        (pipe_flush),
      .exception         (exception),
      .wb                (wb),
      .reg_busy          (reg_busy),
      .pred_busy         (pred_busy)
   );

   always #2 clkrst_core_clk = ~clkrst_core_clk;

   always @(posedge clkrst_core_clk) begin
      cyc <= cyc + 1;
   end

   task automatic stop_on_timeout(string what);
      $display("Timeout at %0t ns: %s", $time, what);
      $display("Regression failed");
      $finish;
   endtask

   `include "tb_core_sb_tasks.svh"

   initial begin
      clkrst_core_clk   = 1'b0;
      clkrst_core_rst_n = 1'b0;
      bundle            = '0;
      bundle_valid      = 1'b0;
      pipe_flush        = 1'b0;
      exception         = 1'b0;
      cyc               = 0;
      seed              = 73;
      errors            = 0;
      tests_run         = 0;
      tests_failed      = 0;
      lat               = i_dut.exec_latency;

      repeat (8) @(posedge clkrst_core_clk);
      clkrst_core_rst_n <= 1'b1;
      @(negedge clkrst_core_clk);
      check_bit("bundle_ready", 1'b0, bundle_ready);
      check_gpr("reg_busy", '0, reg_busy);
      check_pred("pred_busy", '0, pred_busy);
      check_wb("wb", '0, wb);

      test_back_to_back();
      test_raw_hazard();
      test_pred_hazard();
      test_flush();
      test_exception();
      test_waw_hazard();

      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+tests
hw/core_sb_pkg.sv
hw/core_scoreboard.sv
hw/core_issue_ctrl.sv
hw/core_exec_pipe.sv
hw/core_sb_top.sv
tests/tb_core_sb.sv

// File: Bender.yml
package:
  name: core_sb

sources:
  - hw/core_sb_pkg.sv
  - hw/core_scoreboard.sv
  - hw/core_issue_ctrl.sv
  - hw/core_exec_pipe.sv
  - hw/core_sb_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_core_sb.sv
